// File: verilog.f
rtl/tcdm_pkg.sv
rtl/sram_cut.sv
rtl/sram.sv
rtl/tcdm_interleave.sv
rtl/tcdm_top.sv
tests/tb_tcdm_top.sv

// File: Makefile
# Verilator build and run of the TCDM testbench
# the simulator exit status carries pass or fail

VERILATOR ?= verilator
TOP       := tb_tcdm_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_tcdm_top.sv
// ****************************************
// directed testbench for the TCDM top level
// with a word-level reference model
// ****************************************

`timescale 1ns/1ps

module tb_tcdm_top import tcdm_pkg::*; ();

  localparam int unsigned ClkPeriod      = 8;
  localparam int unsigned ResetCycles    = 10;
  localparam int unsigned FullAccesses   = 16;
  localparam int unsigned StrbAccesses   = 30;
  localparam int unsigned DecodeAccesses = 32;
  localparam int unsigned BurstAccesses  = 8;
  localparam int unsigned HoldAccesses   = 8;
  localparam int unsigned RandomAccesses = 400;
  localparam int unsigned WatchdogCycles = ResetCycles + FullAccesses + StrbAccesses
                                         + DecodeAccesses + BurstAccesses + HoldAccesses
                                         + RandomAccesses + 50;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  logic       we_i;
  tcdm_addr_t addr_i;
  data_t      wdata_i;
  strb_t      be_i;
  data_t      rdata_o;

  // reference contents and which words hold defined data
  data_t       model_q [TcdmWords];
  bit          written_q [TcdmWords];
  logic [31:0] rng_q;

  tcdm_top dut_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte-enable rule, enabled bytes come from the new word
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // bank in bits [1:0], cut in bit 12, lowest or highest word of the cut
  function automatic tcdm_addr_t map_addr(input logic [1:0] bank, input logic cut,
                                          input logic high);
    return {cut, high ? 10'h3ff : 10'h000, bank};
  endfunction

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("Mismatch %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "data check failed");
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_cycle();
    req_i = 1'b0;
    we_i  = 1'b0;
    next_cycle();
  endtask

  task automatic write_word(input tcdm_addr_t addr, input data_t data, input strb_t be);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    be_i    = be;
    model_q[addr] = merge_bytes(model_q[addr], data, be);
    if (be == '1) begin
      written_q[addr] = 1'b1;
    end
    next_cycle();
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  // latency is fixed at one cycle, so the word is sampled after one edge
  task automatic read_word(input tcdm_addr_t addr);
    data_t expected;
    expected = model_q[addr];
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    next_cycle();
    check_data($sformatf("rdata_o (addr 0x%04h)", addr), rdata_o, expected);
    req_i = 1'b0;
  endtask

  task automatic test_full_word();
    tcdm_addr_t a;
    for (int i = 0; i < 8; i++) begin
      rng_q = xorshift32(rng_q);
      write_word(tcdm_addr_t'(i * 1237 + 5), rng_q, 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      a = tcdm_addr_t'(i * 1237 + 5);
      read_word(a);
    end
  endtask

  task automatic test_byte_enables();
    strb_t be;
    for (int p = 1; p < 16; p++) begin
      be = p[3:0];
      // single-bit and two-bit patterns only
      if ($countones(be) <= 2) begin
        write_word(13'h0a55, 32'h1122_3344, 4'hf);
        write_word(13'h0a55, 32'haabb_ccdd, be);
        read_word(13'h0a55);
      end
    end
  endtask

  task automatic test_decode();
    for (int i = 0; i < 16; i++) begin
      write_word(map_addr(i[1:0], i[2], i[3]), 32'hc0de_0000 | 32'(i * 32'h0101_0101), 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      read_word(map_addr(i[1:0], i[2], i[3]));
    end
  endtask

  task automatic test_back_to_back();
    tcdm_addr_t a;
    data_t      expected;
    for (int i = 0; i < BurstAccesses; i++) begin
      a        = map_addr(i[1:0], i[0], i[2]);
      expected = model_q[a];
      req_i    = 1'b1;
      we_i     = 1'b0;
      addr_i   = a;
      next_cycle();
      // next request is already on the bus when this word is checked
      check_data($sformatf("rdata_o (burst %0d)", i), rdata_o, expected);
    end
    req_i = 1'b0;
  endtask

  task automatic test_hold();
    tcdm_addr_t a;
    data_t      held;
    a = map_addr(2'd1, 1'b0, 1'b0);
    read_word(a);
    held = model_q[a];
    write_word(a, ~held, 4'hf);
    check_data("rdata_o (after same word write)", rdata_o, held);
    write_word(map_addr(2'd1, 1'b1, 1'b1), 32'h5a5a_0f0f, 4'hf);
    check_data("rdata_o (after other cut write)", rdata_o, held);
    write_word(map_addr(2'd3, 1'b0, 1'b0), 32'h0f0f_5a5a, 4'hf);
    check_data("rdata_o (after other bank write)", rdata_o, held);
    repeat (4) begin
      idle_cycle();
      check_data("rdata_o (idle)", rdata_o, held);
    end
  endtask

  task automatic test_random();
    logic [31:0] r;
    tcdm_addr_t  a;
    strb_t       be;
    data_t       d;
    for (int n = 0; n < RandomAccesses; n++) begin
      rng_q = xorshift32(rng_q);
      r     = rng_q;
      rng_q = xorshift32(rng_q);
      d     = rng_q;
      a     = r[TcdmAddrWidth-1:0];
      be    = r[23:20];
      if (r[16] && written_q[a]) begin
        read_word(a);
      end else begin
        // first touch of a word writes all of it
        if (!written_q[a]) begin
          be = '1;
        end
        write_word(a, d, be);
      end
    end
  endtask

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("run timed out after %0d cycles", WatchdogCycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    rng_q   = 32'h9e96ffd9;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle_cycle();
    test_full_word();
    test_byte_enables();
    test_decode();
    test_back_to_back();
    test_hold();
    test_random();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: rtl/tcdm_top.sv
// ****************************************
// TCDM top: 32 KiB data memory, four
// word-interleaved banks behind one port
// ****************************************

`timescale 1ns/1ps

module tcdm_top import tcdm_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  tcdm_addr_t addr_i,
  input  data_t      wdata_i,
  input  strb_t      be_i,
  output data_t      rdata_o
);

  bank_req_t [NumBanks-1:0] bank_req;
  data_t     [NumBanks-1:0] bank_rdata;

  tcdm_interleave i_tcdm_interleave (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata),
    .rdata_o      (rdata_o)
  );

  // one bank per interleave slot
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram i_sram (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .bank_req_i (bank_req[b]),
      .rdata_o    (bank_rdata[b])
    );
  end

endmodule

// File: rtl/tcdm_interleave.sv
// ****************************************
// TCDM interleaver: word-interleaved bank
// decode and registered read-data return
// ****************************************

`timescale 1ns/1ps

module tcdm_interleave import tcdm_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  tcdm_addr_t                  addr_i,
  input  data_t                       wdata_i,
  input  strb_t                       be_i,
  output bank_req_t [NumBanks-1:0]    bank_req_o,
  input  data_t     [NumBanks-1:0]    bank_rdata_i,
  output data_t                       rdata_o
);

  logic [BankSelWidth-1:0] bank_sel;
  logic [BankSelWidth-1:0] bank_sel_q;
  bank_addr_t              bank_addr;
  logic [NumBanks-1:0]     bank_en;

  // low bits select the bank, the rest is the local word address
  assign bank_sel  = addr_i[BankSelWidth-1:0];
  assign bank_addr = addr_i[TcdmAddrWidth-1:BankSelWidth];

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_en[b]          = req_i && (bank_sel == b);
      // write data and strobes fan out to every bank
      bank_req_o[b].req   = bank_en[b];
      bank_req_o[b].we    = we_i;
      bank_req_o[b].addr  = bank_addr;
      bank_req_o[b].wdata = wdata_i;
      bank_req_o[b].be    = be_i;
    end
  end

  // bank of the last read, writes leave it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_sel_q <= '0;
    end else if (req_i && !we_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  // combinational return mux, no extra cycle
  assign rdata_o = bank_rdata_i[bank_sel_q];

  a_bank_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_en)
  ) else $error("tcdm_interleave: more than one bank requested");

  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_i |-> !$isunknown(addr_i)
  ) else $error("tcdm_interleave: unknown address during request");

endmodule

// File: rtl/sram.sv
// ****************************************
// one TCDM bank built from two SRAM cuts,
// cut select on local address bit 10
// ****************************************

`timescale 1ns/1ps

module sram import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t bank_req_i,
  output data_t     rdata_o
);

  // upper local address bits pick the cut
  logic [BankAddrWidth-1:CutAddrWidth] cut_sel;
  logic [BankAddrWidth-1:CutAddrWidth] cut_sel_q;

  logic [NumCuts-1:0]  cut_req;
  data_t [NumCuts-1:0] cut_rdata;

  assign cut_sel = bank_req_i.addr[BankAddrWidth-1:CutAddrWidth];

  // enable decode, at most one cut sees the request
  always_comb begin
    for (int unsigned c = 0; c < NumCuts; c++) begin
      cut_req[c] = bank_req_i.req && (cut_sel == c);
    end
  end

  // remember which cut answered the last read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cut_sel_q <= '0;
    end else if (bank_req_i.req && !bank_req_i.we) begin
      cut_sel_q <= cut_sel;
    end
  end

  for (genvar c = 0; c < NumCuts; c++) begin : gen_cut
    sram_cut i_sram_cut (
      .clk_i   (clk_i),
      .req_i   (cut_req[c]),
      .we_i    (bank_req_i.we),
      .addr_i  (bank_req_i.addr[CutAddrWidth-1:0]),
      .wdata_i (bank_req_i.wdata),
      .be_i    (bank_req_i.be),
      .rdata_o (cut_rdata[c])
    );
  end

  // cuts hold their output, so the registered select
  // keeps rdata_o stable until the next read
  assign rdata_o = cut_rdata[cut_sel_q];

  a_cut_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(cut_req)
  ) else $error("sram: more than one cut enabled");

endmodule

// File: rtl/sram_cut.sv
// ****************************************
// behavioral 1024 x 32 single-port SRAM cut
// with byte write enables and held read data
// ****************************************

`timescale 1ns/1ps

module sram_cut import tcdm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [CutAddrWidth-1:0] addr_i,
  input  data_t                   wdata_i,
  input  strb_t                   be_i,
  output data_t                   rdata_o
);

  // storage array
  data_t mem_q [CutWords];

  // byte-masked write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read register only loads on a read request,
  // so writes and idle cycles keep the last word
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  // control must be known whenever the cut is enabled
  a_ctrl_known: assert property (
    @(posedge clk_i) req_i |-> !$isunknown({we_i, be_i})
  ) else $error("sram_cut: unknown we/be during request");

endmodule

// File: rtl/tcdm_pkg.sv
// ****************************************
// TCDM shared definitions: memory geometry,
// word types and the per-bank request struct
// ****************************************

package tcdm_pkg;

  // word format
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // one cut is a 1024 x 32 single-port array
  localparam int unsigned CutWords     = 1024;
  localparam int unsigned CutAddrWidth = $clog2(CutWords);

  // a bank stacks its cuts on the upper local address bit
  localparam int unsigned NumCuts       = 2;
  localparam int unsigned BankWords     = NumCuts * CutWords;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  // banks are word-interleaved on the low address bits
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);
  localparam int unsigned TcdmWords     = NumBanks * BankWords;
  localparam int unsigned TcdmAddrWidth = $clog2(TcdmWords);

  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [StrbWidth-1:0]     strb_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  typedef logic [TcdmAddrWidth-1:0] tcdm_addr_t;

  // request toward a single bank, as seen after interleaving
  typedef struct packed {
    logic       req;
    logic       we;
    bank_addr_t addr;
    data_t      wdata;
    strb_t      be;
  } bank_req_t;

endpackage
